/* verilog.f */
+incdir+.
exec_pkg.sv
issue_window.sv
phys_regfile.sv
int_alu.sv
exec_cluster.sv
tb_exec_cluster.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_exec_cluster
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
PASS_TEXT  = TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* exec_tests.svh */
//**************************************************************************
// operation table for the execution cluster testbench
// loads, add/sub flags, logic and shifts, sign extension,
// conditional rows and a dependent chain
//**************************************************************************
`ifndef exec_tests_svh
`define exec_tests_svh

// columns: op, cond, src a, src b, flag src, imm, imm sel, dest, data, flags
// flags nibble is {z, n, v, c}
task automatic load_table();
  add_row(op_movi, cc_al,  0,  0,  0, 32'h0000_1234, 1,  1, 64'h0000_0000_0000_1234, 4'h0);
  add_row(op_movi, cc_al,  0,  0,  0, 32'hffff_fff0, 1,  2, 64'hffff_ffff_ffff_fff0, 4'h4);
  add_row(op_movi, cc_al,  0,  0,  0, 32'h0000_0000, 1,  3, 64'h0000_0000_0000_0000, 4'h8);
  add_row(op_movi, cc_al,  0,  0,  0, 32'h7fff_ffff, 1,  4, 64'h0000_0000_7fff_ffff, 4'h0);
  add_row(op_movi, cc_al,  0,  0,  0, 32'h0000_0001, 1,  5, 64'h0000_0000_0000_0001, 4'h0);
  // carry, overflow and zero
  add_row(op_shl,  cc_al,  5,  0,  0, 32'h0000_003f, 1,  6, 64'h8000_0000_0000_0000, 4'h4);
  add_row(op_sub,  cc_al,  6,  5,  0, 32'h0000_0000, 0,  7, 64'h7fff_ffff_ffff_ffff, 4'h3);
  add_row(op_add,  cc_al,  7,  5,  0, 32'h0000_0000, 0,  8, 64'h8000_0000_0000_0000, 4'h6);
  add_row(op_add,  cc_al,  2,  0,  0, 32'h0000_0010, 1,  9, 64'h0000_0000_0000_0000, 4'h9);
  add_row(op_add,  cc_al,  6,  6,  0, 32'h0000_0000, 0, 10, 64'h0000_0000_0000_0000, 4'hb);
  add_row(op_sub,  cc_al,  1,  1,  0, 32'h0000_0000, 0, 11, 64'h0000_0000_0000_0000, 4'h9);
  add_row(op_sub,  cc_al,  5,  0,  0, 32'h0000_0002, 1, 12, 64'hffff_ffff_ffff_ffff, 4'h4);
  // logic and shifts
  add_row(op_and,  cc_al,  2,  0,  0, 32'h0000_0ff0, 1, 13, 64'h0000_0000_0000_0ff0, 4'h0);
  add_row(op_xor,  cc_al,  2,  2,  0, 32'h0000_0000, 0, 14, 64'h0000_0000_0000_0000, 4'h8);
  add_row(op_or,   cc_al,  1,  0,  0, 32'hffff_0000, 1, 15, 64'hffff_ffff_ffff_1234, 4'h4);
  add_row(op_shr,  cc_al,  6,  0,  0, 32'h0000_003c, 1, 16, 64'h0000_0000_0000_0008, 4'h0);
  add_row(op_sar,  cc_al,  6,  0,  0, 32'h0000_003c, 1, 17, 64'hffff_ffff_ffff_fff8, 4'h4);
  add_row(op_shl,  cc_al,  1,  0,  0, 32'h0000_0044, 1, 18, 64'h0000_0000_0001_2340, 4'h0);
  // sign extension and byte swap
  add_row(op_movi, cc_al,  0,  0,  0, 32'h0123_80f7, 1, 19, 64'h0000_0000_0123_80f7, 4'h0);
  add_row(op_sxt,  cc_al, 19,  0,  0, 32'h0000_0000, 1, 20, 64'hffff_ffff_ffff_fff7, 4'h4);
  add_row(op_sxt,  cc_al, 19,  0,  0, 32'h0000_0001, 1, 21, 64'hffff_ffff_ffff_80f7, 4'h4);
  add_row(op_sxt,  cc_al, 19,  0,  0, 32'h0000_0002, 1, 22, 64'h0000_0000_0123_80f7, 4'h0);
  add_row(op_sxt,  cc_al, 19,  0,  0, 32'h0000_0003, 1, 23, 64'hf780_2301_0000_0000, 4'h4);
  // false conditions pass A and the flags through
  add_row(op_add,  cc_ne,  1,  0,  3, 32'h0000_0001, 1, 24, 64'h0000_0000_0000_1234, 4'h8);
  add_row(op_movi, cc_nv,  5,  0,  2, 32'h0000_0005, 1, 25, 64'h0000_0000_0000_0001, 4'h4);
  add_row(op_sub,  cc_lt,  1,  0,  8, 32'h0000_0001, 1, 26, 64'h0000_0000_0000_1234, 4'h6);
  add_row(op_add,  cc_ge,  1,  0,  8, 32'h0000_0001, 1, 27, 64'h0000_0000_0000_1235, 4'h0);
  add_row(op_or,   cc_hi,  1,  0,  7, 32'h0001_0000, 1, 28, 64'h0000_0000_0001_1234, 4'h0);
  add_row(op_and,  cc_hi,  1,  0,  9, 32'h0000_0000, 1, 29, 64'h0000_0000_0000_1234, 4'h9);
  add_row(op_xor,  cc_le,  1,  0, 11, 32'h0000_1234, 1, 30, 64'h0000_0000_0000_0000, 4'h8);
  // dependent chain, no idle cycles between rows
  burst_start = row_op.size();
  add_row(op_add,  cc_al,  1,  0,  0, 32'h0000_0001, 1, 31, 64'h0000_0000_0000_1235, 4'h0);
  add_row(op_add,  cc_al, 31, 31,  0, 32'h0000_0000, 0, 32, 64'h0000_0000_0000_246a, 4'h0);
  add_row(op_shl,  cc_al, 32,  0,  0, 32'h0000_0004, 1, 33, 64'h0000_0000_0002_46a0, 4'h0);
  add_row(op_sub,  cc_al, 33,  0,  0, 32'h0002_46a0, 1, 34, 64'h0000_0000_0000_0000, 4'h9);
  add_row(op_add,  cc_eq, 33,  0, 34, 32'h0000_0060, 1, 35, 64'h0000_0000_0002_4700, 4'h0);
  add_row(op_sxt,  cc_al, 35,  0,  0, 32'h0000_0001, 1, 36, 64'h0000_0000_0000_4700, 4'h0);
  add_row(op_sub,  cc_al, 36, 35,  0, 32'h0000_0000, 0, 37, 64'hffff_ffff_fffe_0000, 4'h4);
  add_row(op_sar,  cc_al, 37,  0,  0, 32'h0000_0011, 1, 38, 64'hffff_ffff_ffff_ffff, 4'h4);
  add_row(op_add,  cc_al, 38,  0,  0, 32'h0000_0001, 1, 39, 64'h0000_0000_0000_0000, 4'h9);
  add_row(op_movi, cc_eq, 38,  0, 39, 32'h0000_0007, 1, 40, 64'h0000_0000_0000_0007, 4'h0);
endtask

`endif

/* tb_exec_cluster.sv */
//**************************************************************************
// testbench for the integer execution cluster
// clock and reset, table-driven dispatch loop, writeback checker,
// cycle limit and verdict
//**************************************************************************
module tb_exec_cluster;
  timeunit 1ns;
  timeprecision 1ps;
  import exec_pkg::*;

  logic              clk;
  logic              rst;
  logic              disp_valid;
  op_e               disp_op;
  cond_e             disp_cond;
  logic [tag_w-1:0]  disp_src_a, disp_src_b, disp_src_f, disp_dest;
  logic [imm_w-1:0]  disp_imm;
  logic              disp_imm_sel;
  logic              window_full;
  logic              wb_valid;
  logic [tag_w-1:0]  wb_tag;
  logic [data_w-1:0] wb_data;
  logic [flag_w-1:0] wb_flags;

  // one entry per table row
  op_e               row_op[$];
  cond_e             row_cond[$];
  logic [tag_w-1:0]  row_a[$], row_b[$], row_f[$], row_dest[$];
  logic [imm_w-1:0]  row_imm[$];
  logic              row_isel[$];
  logic [data_w-1:0] row_data[$];
  logic [flag_w-1:0] row_flags[$];
  int                wb_count[$];
  int                row_of_tag[num_pregs];
  int                burst_start;   // rows from here on go back to back
  int                total_wb;
  int                cycles;
  int                max_cycles;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("[FAIL] t=%0t %s got %h expected %h",
                                  $time, name, got, exp));
  endtask

  task automatic add_row(input op_e op, input cond_e cc, input int a, input int b,
                         input int f, input logic [imm_w-1:0] imm, input int isel,
                         input int dest, input logic [data_w-1:0] data,
                         input logic [flag_w-1:0] flags);
    row_op.push_back(op);
    row_cond.push_back(cc);
    row_a.push_back(tag_w'(a));
    row_b.push_back(tag_w'(b));
    row_f.push_back(tag_w'(f));
    row_imm.push_back(imm);
    row_isel.push_back(isel != 0);
    row_dest.push_back(tag_w'(dest));
    row_data.push_back(data);
    row_flags.push_back(flags);
    wb_count.push_back(0);
    row_of_tag[dest] = row_op.size() - 1;
  endtask

  `include "exec_tests.svh"

  task automatic apply_row(input int i);
    disp_valid   = 1'b1;
    disp_op      = row_op[i];
    disp_cond    = row_cond[i];
    disp_src_a   = row_a[i];
    disp_src_b   = row_b[i];
    disp_src_f   = row_f[i];
    disp_imm     = row_imm[i];
    disp_imm_sel = row_isel[i];
    disp_dest    = row_dest[i];
  endtask

  exec_cluster u_exec_cluster (
    .clk, .rst,
    .disp_valid, .disp_op, .disp_cond, .disp_src_a, .disp_src_b, .disp_src_f,
    .disp_dest, .disp_imm, .disp_imm_sel,
    .window_full, .wb_valid, .wb_tag, .wb_data, .wb_flags
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles)
      stop_with_failure($sformatf("timeout: run still busy after %0d cycles", cycles));
  end

  // writeback checker, sampled mid-cycle
  always @(negedge clk) begin
    int idx;
    if (!rst && wb_valid) begin
      idx = row_of_tag[wb_tag];
      if (idx < 0) begin
        stop_with_failure($sformatf("writeback to tag %0d, which no row targets", wb_tag));
      end else begin
        check_value("wb_data", wb_data, row_data[idx]);
        check_value("wb_flags", 64'(wb_flags), 64'(row_flags[idx]));
        wb_count[idx]++;
        total_wb++;
      end
    end
  end

  initial begin
    int gap;
    int bad;
    void'($urandom(32'h2831));
    clk          = 1'b0;
    rst          = 1'b1;
    disp_valid   = 1'b0;
    disp_op      = op_add;
    disp_cond    = cc_al;
    disp_src_a   = '0;
    disp_src_b   = '0;
    disp_src_f   = '0;
    disp_dest    = '0;
    disp_imm     = '0;
    disp_imm_sel = 1'b0;
    total_wb     = 0;
    cycles       = 0;
    burst_start  = 0;
    for (int t = 0; t < num_pregs; t++) row_of_tag[t] = -1;
    load_table();
    max_cycles = row_op.size() * 8 + 100;

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("wb_valid", 64'(wb_valid), 64'd0);
    check_value("window_full", 64'(window_full), 64'd0);

    for (int i = 0; i < row_op.size(); i++) begin
      while (window_full) begin
        @(posedge clk);
        #1;
      end
      apply_row(i);
      @(posedge clk);
      #1;
      disp_valid = 1'b0;
      gap = (i + 1 >= burst_start) ? 0 : int'($urandom % 3);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end

    while (total_wb < row_op.size()) @(posedge clk);
    repeat (4) @(posedge clk);   // room for a stray second writeback
    bad = 0;
    foreach (wb_count[i]) begin
      if (wb_count[i] != 1) bad++;
    end
    if (bad != 0) begin
      stop_with_failure($sformatf("%0d rows did not write back exactly once", bad));
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* exec_cluster.sv */
//**************************************************************************
// integer execution cluster top
// issue window, physical register file and one ALU
//**************************************************************************
module exec_cluster (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            disp_valid,
  input  exec_pkg::op_e                   disp_op,
  input  exec_pkg::cond_e                 disp_cond,
  input  logic [exec_pkg::tag_w-1:0]      disp_src_a,
  input  logic [exec_pkg::tag_w-1:0]      disp_src_b,
  input  logic [exec_pkg::tag_w-1:0]      disp_src_f,
  input  logic [exec_pkg::tag_w-1:0]      disp_dest,
  input  logic [exec_pkg::imm_w-1:0]      disp_imm,
  input  logic                            disp_imm_sel,
  output logic                            window_full,
  output logic                            wb_valid,
  output logic [exec_pkg::tag_w-1:0]      wb_tag,
  output logic [exec_pkg::data_w-1:0]     wb_data,
  output logic [exec_pkg::flag_w-1:0]     wb_flags
);
  import exec_pkg::*;

  logic              iss_valid;
  op_e               iss_op;
  cond_e             iss_cond;
  logic [tag_w-1:0]  iss_src_a, iss_src_b, iss_src_f, iss_dest;
  logic [imm_w-1:0]  iss_imm;
  logic              iss_imm_sel;
  logic [data_w-1:0] rd_a_data, rd_b_data;
  logic [flag_w-1:0] rd_f_flags;
  logic              sb_valid_a, sb_valid_b, sb_valid_f;

  issue_window u_issue_window (
    .clk, .rst,
    .disp_valid, .disp_op, .disp_cond, .disp_src_a, .disp_src_b, .disp_src_f,
    .disp_dest, .disp_imm, .disp_imm_sel,
    .sb_valid_a, .sb_valid_b, .sb_valid_f,
    .wb_valid, .wb_tag,
    .window_full,
    .iss_valid, .iss_op, .iss_cond, .iss_src_a, .iss_src_b, .iss_src_f,
    .iss_dest, .iss_imm, .iss_imm_sel
  );

  // scoreboard looked up with the dispatch sources, dest cleared on dispatch
  phys_regfile u_phys_regfile (
    .clk, .rst,
    .rd_a_tag (iss_src_a),
    .rd_b_tag (iss_src_b),
    .rd_f_tag (iss_src_f),
    .sb_tag_a (disp_src_a),
    .sb_tag_b (disp_src_b),
    .sb_tag_f (disp_src_f),
    .alloc_valid (disp_valid),
    .alloc_tag   (disp_dest),
    .wb_valid, .wb_tag, .wb_data, .wb_flags,
    .rd_a_data, .rd_b_data, .rd_f_flags,
    .sb_valid_a, .sb_valid_b, .sb_valid_f
  );

  int_alu u_int_alu (
    .clk, .rst,
    .iss_valid, .iss_op, .iss_cond, .iss_imm, .iss_imm_sel, .iss_dest,
    .rd_a_data, .rd_b_data, .rd_f_flags,
    .wb_valid, .wb_tag, .wb_data, .wb_flags
  );

endmodule

/* int_alu.sv */
//**************************************************************************
// flag-conditional integer ALU
// condition check, add/sub/logic/shift/sxt/movi, flag generation
// and the writeback register
//**************************************************************************
module int_alu (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            iss_valid,
  input  exec_pkg::op_e                   iss_op,
  input  exec_pkg::cond_e                 iss_cond,
  input  logic [exec_pkg::imm_w-1:0]      iss_imm,
  input  logic                            iss_imm_sel,
  input  logic [exec_pkg::tag_w-1:0]      iss_dest,
  input  logic [exec_pkg::data_w-1:0]     rd_a_data,
  input  logic [exec_pkg::data_w-1:0]     rd_b_data,
  input  logic [exec_pkg::flag_w-1:0]     rd_f_flags,
  output logic                            wb_valid,
  output logic [exec_pkg::tag_w-1:0]      wb_tag,
  output logic [exec_pkg::data_w-1:0]     wb_data,
  output logic [exec_pkg::flag_w-1:0]     wb_flags
);
  import exec_pkg::*;

  logic [data_w-1:0] opa;
  logic [data_w-1:0] opb;
  logic [data_w-1:0] imm_ext;
  logic [data_w-1:0] op_res;
  logic [data_w-1:0] res;
  logic [data_w-1:0] swapped;
  logic [flag_w-1:0] res_flags;
  logic              op_c, op_v;
  logic              cond_ok;

  function automatic logic cond_true(input cond_e cc, input logic [flag_w-1:0] fl);
    logic c, v, n, z;
    c = fl[flag_c];
    v = fl[flag_v];
    n = fl[flag_n];
    z = fl[flag_z];
    case (cc)
      cc_eq:   return z;
      cc_ne:   return !z;
      cc_cs:   return c;
      cc_cc:   return !c;
      cc_mi:   return n;
      cc_pl:   return !n;
      cc_vs:   return v;
      cc_vc:   return !v;
      cc_hi:   return c && !z;
      cc_ls:   return !c || z;
      cc_ge:   return n == v;
      cc_lt:   return n != v;
      cc_gt:   return !z && (n == v);
      cc_le:   return z || (n != v);
      cc_al:   return 1'b1;
      default: return 1'b0;  // cc_nv
    endcase
  endfunction

  assign opa     = rd_a_data;
  assign imm_ext = {{(data_w - imm_w){iss_imm[imm_w-1]}}, iss_imm};
  assign opb     = iss_imm_sel ? imm_ext : rd_b_data;
  assign cond_ok = cond_true(iss_cond, rd_f_flags);

  always_comb begin
    for (int i = 0; i < data_w / 8; i++) begin
      swapped[8*i +: 8] = opa[data_w - 8 - 8*i +: 8];
    end
  end

  always_comb begin
    op_c   = 1'b0;
    op_v   = 1'b0;
    op_res = '0;
    case (iss_op)
      op_add: begin
        {op_c, op_res} = {1'b0, opa} + {1'b0, opb};
        op_v = (opa[data_w-1] == opb[data_w-1]) && (op_res[data_w-1] != opa[data_w-1]);
      end
      op_sub: begin
        op_res = opa - opb;
        op_c   = (opa >= opb);  // no borrow
        op_v   = (opa[data_w-1] != opb[data_w-1]) && (op_res[data_w-1] != opa[data_w-1]);
      end
      op_and: op_res = opa & opb;
      op_xor: op_res = opa ^ opb;
      op_or:  op_res = opa | opb;
      op_shl: op_res = opa << opb[5:0];
      op_shr: op_res = opa >> opb[5:0];
      op_sar: op_res = $signed(opa) >>> opb[5:0];
      op_sxt: begin
        case (opb[1:0])
          2'd0:    op_res = {{(data_w - 8){opa[7]}}, opa[7:0]};
          2'd1:    op_res = {{(data_w - 16){opa[15]}}, opa[15:0]};
          2'd2:    op_res = {{(data_w - 32){opa[31]}}, opa[31:0]};
          default: op_res = swapped;
        endcase
      end
      op_movi: op_res = opb;
      default: op_res = '0;
    endcase
  end

  // false condition keeps A and the source flags
  always_comb begin
    if (cond_ok) begin
      res                 = op_res;
      res_flags[flag_c]   = op_c;
      res_flags[flag_v]   = op_v;
      res_flags[flag_n]   = op_res[data_w-1];
      res_flags[flag_z]   = (op_res == '0);
    end else begin
      res       = opa;
      res_flags = rd_f_flags;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) wb_valid <= 1'b0;
    else     wb_valid <= iss_valid;
  end

  always_ff @(posedge clk) begin
    wb_tag   <= iss_dest;
    wb_data  <= res;
    wb_flags <= res_flags;
  end

  a_wb_follows_issue: assert property (@(posedge clk) disable iff (rst)
    iss_valid |=> wb_valid && wb_tag == $past(iss_dest));

endmodule

/* phys_regfile.sv */
//**************************************************************************
// physical register file
// 64 data words with flag nibbles and a valid scoreboard,
// three combinational read ports, one writeback port
//**************************************************************************
module phys_regfile (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [exec_pkg::tag_w-1:0]      rd_a_tag,
  input  logic [exec_pkg::tag_w-1:0]      rd_b_tag,
  input  logic [exec_pkg::tag_w-1:0]      rd_f_tag,
  input  logic [exec_pkg::tag_w-1:0]      sb_tag_a,
  input  logic [exec_pkg::tag_w-1:0]      sb_tag_b,
  input  logic [exec_pkg::tag_w-1:0]      sb_tag_f,
  input  logic                            alloc_valid,
  input  logic [exec_pkg::tag_w-1:0]      alloc_tag,
  input  logic                            wb_valid,
  input  logic [exec_pkg::tag_w-1:0]      wb_tag,
  input  logic [exec_pkg::data_w-1:0]     wb_data,
  input  logic [exec_pkg::flag_w-1:0]     wb_flags,
  output logic [exec_pkg::data_w-1:0]     rd_a_data,
  output logic [exec_pkg::data_w-1:0]     rd_b_data,
  output logic [exec_pkg::flag_w-1:0]     rd_f_flags,
  output logic                            sb_valid_a,
  output logic                            sb_valid_b,
  output logic                            sb_valid_f
);
  import exec_pkg::*;

  logic [data_w-1:0]    data_mem [num_pregs];
  logic [flag_w-1:0]    flag_mem [num_pregs];
  logic [num_pregs-1:0] valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      // every register starts as a valid zero
      for (int i = 0; i < num_pregs; i++) begin
        data_mem[i] <= '0;
        flag_mem[i] <= '0;
      end
      valid <= '1;
    end else begin
      if (alloc_valid) valid[alloc_tag] <= 1'b0;  // result now in flight
      if (wb_valid) begin
        data_mem[wb_tag] <= wb_data;
        flag_mem[wb_tag] <= wb_flags;
        valid[wb_tag]    <= 1'b1;
      end
    end
  end

  // operand reads for the issued op
  assign rd_a_data  = data_mem[rd_a_tag];
  assign rd_b_data  = data_mem[rd_b_tag];
  assign rd_f_flags = flag_mem[rd_f_tag];

  // scoreboard lookups for the op being dispatched
  assign sb_valid_a = valid[sb_tag_a];
  assign sb_valid_b = valid[sb_tag_b];
  assign sb_valid_f = valid[sb_tag_f];

  // a writeback lands only on a register that dispatch marked in flight
  a_wb_pending: assert property (@(posedge clk) disable iff (rst)
    wb_valid |-> !valid[wb_tag]);

endmodule

/* issue_window.sv */
//**************************************************************************
// operation window for the integer unit
// slot allocation, tag wakeup from writeback, lowest-ready select
// and the issue register
//**************************************************************************
module issue_window (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            disp_valid,
  input  exec_pkg::op_e                   disp_op,
  input  exec_pkg::cond_e                 disp_cond,
  input  logic [exec_pkg::tag_w-1:0]      disp_src_a,
  input  logic [exec_pkg::tag_w-1:0]      disp_src_b,
  input  logic [exec_pkg::tag_w-1:0]      disp_src_f,
  input  logic [exec_pkg::tag_w-1:0]      disp_dest,
  input  logic [exec_pkg::imm_w-1:0]      disp_imm,
  input  logic                            disp_imm_sel,
  input  logic                            sb_valid_a,
  input  logic                            sb_valid_b,
  input  logic                            sb_valid_f,
  input  logic                            wb_valid,
  input  logic [exec_pkg::tag_w-1:0]      wb_tag,
  output logic                            window_full,
  output logic                            iss_valid,
  output exec_pkg::op_e                   iss_op,
  output exec_pkg::cond_e                 iss_cond,
  output logic [exec_pkg::tag_w-1:0]      iss_src_a,
  output logic [exec_pkg::tag_w-1:0]      iss_src_b,
  output logic [exec_pkg::tag_w-1:0]      iss_src_f,
  output logic [exec_pkg::tag_w-1:0]      iss_dest,
  output logic [exec_pkg::imm_w-1:0]      iss_imm,
  output logic                            iss_imm_sel
);
  import exec_pkg::*;

  // per-entry state
  logic [win_depth-1:0] busy;
  logic [win_depth-1:0] rdy_a;
  logic [win_depth-1:0] rdy_b;
  logic [win_depth-1:0] rdy_f;
  op_e                  ent_op    [win_depth];
  cond_e                ent_cond  [win_depth];
  logic [tag_w-1:0]     ent_src_a [win_depth];
  logic [tag_w-1:0]     ent_src_b [win_depth];
  logic [tag_w-1:0]     ent_src_f [win_depth];
  logic [tag_w-1:0]     ent_dest  [win_depth];
  logic [imm_w-1:0]     ent_imm   [win_depth];
  logic                 ent_imm_sel [win_depth];

  logic [win_depth-1:0] ready_vec;
  logic                 has_ready;
  logic [win_idx_w-1:0] sel_idx;
  logic [win_idx_w-1:0] free_idx;
  logic                 need_a, need_b, need_f;
  logic                 in_rdy_a, in_rdy_b, in_rdy_f;

  // lowest set bit wins
  function automatic logic [win_idx_w-1:0] lowest_set(input logic [win_depth-1:0] vec);
    logic [win_idx_w-1:0] idx;
    idx = '0;
    for (int i = win_depth - 1; i >= 0; i--) begin
      if (vec[i]) idx = win_idx_w'(i);
    end
    return idx;
  endfunction

  assign ready_vec   = busy & rdy_a & rdy_b & rdy_f;
  assign has_ready   = |ready_vec;
  assign sel_idx     = lowest_set(ready_vec);
  assign free_idx    = lowest_set(~busy);
  assign window_full = &busy;

  // a false condition passes A through, so A only drops out for an unconditional movi
  assign need_a = (disp_op != op_movi) || (disp_cond != cc_al);
  assign need_b = !disp_imm_sel && (disp_op != op_movi);
  assign need_f = (disp_cond != cc_al);

  // same-cycle writeback counts as ready
  assign in_rdy_a = !need_a || sb_valid_a || (wb_valid && wb_tag == disp_src_a);
  assign in_rdy_b = !need_b || sb_valid_b || (wb_valid && wb_tag == disp_src_b);
  assign in_rdy_f = !need_f || sb_valid_f || (wb_valid && wb_tag == disp_src_f);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= '0;
      rdy_a <= '0;
      rdy_b <= '0;
      rdy_f <= '0;
    end else begin
      for (int i = 0; i < win_depth; i++) begin  // wakeup
        if (wb_valid && ent_src_a[i] == wb_tag) rdy_a[i] <= 1'b1;
        if (wb_valid && ent_src_b[i] == wb_tag) rdy_b[i] <= 1'b1;
        if (wb_valid && ent_src_f[i] == wb_tag) rdy_f[i] <= 1'b1;
      end
      if (has_ready) busy[sel_idx] <= 1'b0;
      if (disp_valid) begin
        busy[free_idx]  <= 1'b1;
        rdy_a[free_idx] <= in_rdy_a;
        rdy_b[free_idx] <= in_rdy_b;
        rdy_f[free_idx] <= in_rdy_f;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (disp_valid) begin
      ent_op[free_idx]      <= disp_op;
      ent_cond[free_idx]    <= disp_cond;
      ent_src_a[free_idx]   <= disp_src_a;
      ent_src_b[free_idx]   <= disp_src_b;
      ent_src_f[free_idx]   <= disp_src_f;
      ent_dest[free_idx]    <= disp_dest;
      ent_imm[free_idx]     <= disp_imm;
      ent_imm_sel[free_idx] <= disp_imm_sel;
    end
  end

  // issue register
  always_ff @(posedge clk) begin
    if (rst) iss_valid <= 1'b0;
    else     iss_valid <= has_ready;
  end

  always_ff @(posedge clk) begin
    iss_op      <= ent_op[sel_idx];
    iss_cond    <= ent_cond[sel_idx];
    iss_src_a   <= ent_src_a[sel_idx];
    iss_src_b   <= ent_src_b[sel_idx];
    iss_src_f   <= ent_src_f[sel_idx];
    iss_dest    <= ent_dest[sel_idx];
    iss_imm     <= ent_imm[sel_idx];
    iss_imm_sel <= ent_imm_sel[sel_idx];
  end

  a_no_disp_full: assert property (@(posedge clk) disable iff (rst)
    disp_valid |-> !window_full);

  // the issued entry goes from busy to free
  a_issue_busy: assert property (@(posedge clk) disable iff (rst)
    iss_valid |-> $past(busy[sel_idx]) && !busy[$past(sel_idx)]);

endmodule

/* exec_pkg.sv */
//**************************************************************************
// shared definitions for the integer execution cluster
// operand, tag and window sizes, opcode and condition enums,
// flag bit positions
//**************************************************************************
package exec_pkg;

  localparam int data_w    = 64;
  localparam int tag_w     = 6;
  localparam int num_pregs = 1 << tag_w;
  localparam int win_depth = 16;
  localparam int win_idx_w = 4;
  localparam int imm_w     = 32;    // sign-extended to data_w
  localparam int flag_w    = 4;

  // flag nibble layout
  localparam int flag_c = 0;
  localparam int flag_v = 1;
  localparam int flag_n = 2;
  localparam int flag_z = 3;

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_xor  = 4'd3,
    op_or   = 4'd4,
    op_shl  = 4'd5,
    op_shr  = 4'd6,
    op_sar  = 4'd7,
    op_sxt  = 4'd8,   // sign extend or byte swap, picked by b[1:0]
    op_movi = 4'd9
  } op_e;

  typedef enum logic [3:0] {
    cc_eq = 4'd0,
    cc_ne = 4'd1,
    cc_cs = 4'd2,
    cc_cc = 4'd3,
    cc_mi = 4'd4,
    cc_pl = 4'd5,
    cc_vs = 4'd6,
    cc_vc = 4'd7,
    cc_hi = 4'd8,   // unsigned higher
    cc_ls = 4'd9,
    cc_ge = 4'd10,  // signed compares
    cc_lt = 4'd11,
    cc_gt = 4'd12,
    cc_le = 4'd13,
    cc_al = 4'd14,
    cc_nv = 4'd15
  } cond_e;

endpackage
